//--- div_unit.f
source/div_pkg.sv
source/srt_qselect.sv
source/div_prescale.sv
source/div_iter.sv
source/div_post.sv
source/div_unit.sv
test/tb_div_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the divider with its testbench, run it, then scan the log for the verdict
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f div_unit.f --top-module tb_div_unit \
    -o sim_div_unit \
    && ./obj_dir/sim_div_unit 2>&1 | tee sim.log \
    || echo "build or run of the simulation ended with an error" | tee -a sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no verdict found in sim.log"; exit 1; }
echo "simulation passed"

//--- source/div_iter.sv
module div_iter (
    input  logic               clk,
    input  logic               rst,
    input  logic               work_valid_i,
    output logic               work_ready_o,
    input  div_pkg::div_work_t work_i,
    output logic               quot_valid_o,
    input  logic               quot_ready_i,
    output div_pkg::div_quot_t quot_o
);
    import div_pkg::*;

    localparam int CNT_W = $clog2(ITER_STEPS + 1);

    logic [CNT_W-1:0] cnt;
    logic             done;
    logic             busy;
    logic             load;
    logic [PA_W-1:0]  pa;
    logic [PA_W-1:0]  pa_sh;
    logic [PA_W-1:0]  pa_nxt;
    logic [PA_W-1:0]  b_x1;
    logic [PA_W-1:0]  b_x2;
    logic [XLEN-1:0]  b;
    logic [XLEN-1:0]  q_pos;
    logic [XLEN-1:0]  q_neg;
    logic [XLEN-1:0]  q_pos_nxt;
    logic [XLEN-1:0]  q_neg_nxt;
    logic [XLEN-1:0]  weight;
    div_flags_t       flags;
    qdigit_t          qd;

    srt_qselect u_qsel (
        .b_i (b[XLEN-1 -: 4]),
        .p_i (pa[PA_W-1 -: 6]),
        .q_o (qd)
    );

    assign busy         = (cnt != '0);
    assign work_ready_o = ~busy & ~done;
    assign quot_valid_o = done;
    assign load         = work_valid_i & work_ready_o;

    // the divisor is aligned one bit below the sign of the partial remainder
    assign pa_sh  = pa << 2;
    assign b_x1   = {1'b0, b, {XLEN{1'b0}}};
    assign b_x2   = {b, {(XLEN+1){1'b0}}};
    assign weight = {{(XLEN-1){1'b0}}, 1'b1} << {cnt - 1'b1, 1'b0};  // 4^(steps left - 1)

    always_comb begin
        pa_nxt    = pa_sh;
        q_pos_nxt = q_pos;
        q_neg_nxt = q_neg;
        case (qd)
            QD_N2: begin
                pa_nxt    = pa_sh + b_x2;
                q_neg_nxt = q_neg + (weight << 1);
            end
            QD_N1: begin
                pa_nxt    = pa_sh + b_x1;
                q_neg_nxt = q_neg + weight;
            end
            QD_P1: begin
                pa_nxt    = pa_sh - b_x1;
                q_pos_nxt = q_pos + weight;
            end
            QD_P2: begin
                pa_nxt    = pa_sh - b_x2;
                q_pos_nxt = q_pos + (weight << 1);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            if (load) begin
                cnt <= CNT_W'(ITER_STEPS);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
            if (busy && cnt == CNT_W'(1)) begin
                done <= 1'b1;  // last digit retires on this edge
            end else if (done && quot_ready_i) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pa    <= work_i.pa;
            b     <= work_i.b;
            flags <= work_i.flags;
            q_pos <= '0;
            q_neg <= '0;
        end else if (busy) begin
            pa    <= pa_nxt;
            q_pos <= q_pos_nxt;
            q_neg <= q_neg_nxt;
        end
    end

    assign quot_o.pa    = pa;
    assign quot_o.b     = b;
    assign quot_o.q_pos = q_pos;
    assign quot_o.q_neg = q_neg;
    assign quot_o.flags = flags;

    // the selection table must only ever hand back one of the five digits
    a_digit_legal: assert property (@(posedge clk) disable iff (!rst)
        busy |-> (qd inside {QD_N2, QD_N1, QD_Z, QD_P1, QD_P2}));

endmodule

//--- source/div_pkg.sv
package div_pkg;

    localparam int XLEN       = 32;
    localparam int PA_W       = 2 * XLEN + 1;  // partial remainder plus its sign bit
    localparam int LZC_W      = 5;
    localparam int ITER_STEPS = XLEN / 2;      // two quotient bits retire per step

    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_e;

    typedef struct packed {
        div_op_e         op;
        logic [XLEN-1:0] dividend;
        logic [XLEN-1:0] divisor;
    } div_req_t;

    // per-operation bookkeeping that rides along with the datapath
    typedef struct packed {
        logic             sext;  // signed operation
        logic             rem;   // remainder requested
        logic             zero;  // divisor is zero
        logic             ov;    // most negative value divided by -1
        logic             ha;    // dividend sign
        logic             hb;    // divisor sign
        logic [LZC_W-1:0] lzc;
        logic [XLEN-1:0]  src1;  // original dividend for the special cases
    } div_flags_t;

    typedef struct packed {
        logic [PA_W-1:0] pa;
        logic [XLEN-1:0] b;
        div_flags_t      flags;
    } div_work_t;

    typedef struct packed {
        logic [PA_W-1:0] pa;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] q_pos;
        logic [XLEN-1:0] q_neg;
        div_flags_t      flags;
    } div_quot_t;

    // signed quotient digit, two's complement in three bits
    typedef enum logic [2:0] {
        QD_Z  = 3'b000,
        QD_P1 = 3'b001,
        QD_P2 = 3'b010,
        QD_N2 = 3'b110,
        QD_N1 = 3'b111
    } qdigit_t;

endpackage

//--- source/div_post.sv
module div_post (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  quot_valid_i,
    output logic                  quot_ready_o,
    input  div_pkg::div_quot_t    quot_i,
    output logic                  res_valid_o,
    input  logic                  res_ready_i,
    output logic [div_pkg::XLEN-1:0] res_o
);
    import div_pkg::*;

    div_flags_t      f;
    logic            take;
    logic            unit_div;
    logic [PA_W-1:0] pa_fix;
    logic [PA_W-1:0] pa_den;
    logic [XLEN-1:0] q_neg_fix;
    logic [XLEN-1:0] q_hi;
    logic [XLEN-1:0] q_lo;
    logic [XLEN-1:0] rem_mag;
    logic [XLEN-1:0] quot;
    logic [XLEN-1:0] rem;

    assign f            = quot_i.flags;
    assign quot_ready_o = ~res_valid_o | res_ready_i;  // empty, or emptied this cycle
    assign take         = quot_valid_i & quot_ready_o;

    // a divisor of magnitude one needs a quotient beyond what sixteen digits can reach
    assign unit_div = ~f.zero && (f.lzc == LZC_W'(XLEN - 1));

    // a negative final remainder means the quotient came out one too large
    always_comb begin
        pa_fix    = quot_i.pa;
        q_neg_fix = quot_i.q_neg;
        if (quot_i.pa[PA_W-1]) begin
            pa_fix    = quot_i.pa + {1'b0, quot_i.b, {XLEN{1'b0}}};
            q_neg_fix = quot_i.q_neg + 1'b1;
        end
    end

    // swapping the accumulators negates the quotient for mixed signs
    assign q_hi = (f.sext && (f.ha ^ f.hb)) ? q_neg_fix : quot_i.q_pos;
    assign q_lo = (f.sext && (f.ha ^ f.hb)) ? quot_i.q_pos : q_neg_fix;

    assign pa_den  = pa_fix >> f.lzc;
    assign rem_mag = pa_den[2*XLEN-1:XLEN];

    always_comb begin
        quot = q_hi - q_lo;
        rem  = (f.sext && f.ha) ? (~rem_mag + 1'b1) : rem_mag;
        if (f.zero) begin
            quot = '1;
            rem  = f.src1;
        end else if (f.ov) begin
            quot = f.src1;
            rem  = '0;
        end else if (unit_div) begin
            quot = (f.sext && f.hb) ? (~f.src1 + 1'b1) : f.src1;
            rem  = '0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            res_valid_o <= 1'b0;
        end else if (take) begin
            res_valid_o <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_o <= f.rem ? rem : quot;
        end
    end

    // a result that is not taken must not move
    a_res_hold: assert property (@(posedge clk) disable iff (!rst)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)));

endmodule

//--- source/div_prescale.sv
module div_prescale (
    input  div_pkg::div_req_t  req_i,
    output div_pkg::div_work_t work_o
);
    import div_pkg::*;

    div_flags_t       flags;
    logic [XLEN-1:0]  abs_a;
    logic [XLEN-1:0]  abs_b;
    logic [LZC_W-1:0] lzc;

    always_comb begin
        case (req_i.op)
            OP_DIV: begin
                flags.sext = 1'b1;
                flags.rem  = 1'b0;
            end
            OP_DIVU: begin
                flags.sext = 1'b0;
                flags.rem  = 1'b0;
            end
            OP_REM: begin
                flags.sext = 1'b1;
                flags.rem  = 1'b1;
            end
            default: begin
                flags.sext = 1'b0;
                flags.rem  = 1'b1;
            end
        endcase
    end

    assign flags.zero = (req_i.divisor == '0);
    assign flags.ov   = flags.sext && (req_i.dividend == {1'b1, {XLEN-1{1'b0}}})
                        && (req_i.divisor == '1);
    assign flags.ha   = req_i.dividend[XLEN-1];
    assign flags.hb   = req_i.divisor[XLEN-1];
    assign flags.lzc  = lzc;
    assign flags.src1 = req_i.dividend;

    assign abs_a = (flags.sext && flags.ha) ? (~req_i.dividend + 1'b1) : req_i.dividend;
    assign abs_b = (flags.sext && flags.hb) ? (~req_i.divisor + 1'b1) : req_i.divisor;

    // the highest set bit is seen last, so it sets the count
    always_comb begin
        lzc = '0;
        for (int i = 0; i < XLEN; i++) begin
            if (abs_b[i]) begin
                lzc = LZC_W'(XLEN - 1 - i);
            end
        end
    end

    // the divisor ends up with its top bit set, the dividend moves with it
    assign work_o.pa    = {{(PA_W-XLEN){1'b0}}, abs_a} << lzc;
    assign work_o.b     = abs_b << lzc;
    assign work_o.flags = flags;

endmodule

//--- source/div_unit.sv
module div_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  div_pkg::div_req_t        req_i,
    output logic                     res_valid_o,
    input  logic                     res_ready_i,
    output logic [div_pkg::XLEN-1:0] res_o
);
    import div_pkg::*;

    div_work_t work;
    div_quot_t quot;
    logic      quot_valid;
    logic      quot_ready;

    div_prescale u_prescale (
        .req_i  (req_i),
        .work_o (work)
    );

    // the engine accepts only when idle, so its ready is the request ready
    div_iter u_iter (
        .clk          (clk),
        .rst          (rst),
        .work_valid_i (req_valid_i),
        .work_ready_o (req_ready_o),
        .work_i       (work),
        .quot_valid_o (quot_valid),
        .quot_ready_i (quot_ready),
        .quot_o       (quot)
    );

    div_post u_post (
        .clk          (clk),
        .rst          (rst),
        .quot_valid_i (quot_valid),
        .quot_ready_o (quot_ready),
        .quot_i       (quot),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .res_o        (res_o)
    );

endmodule

//--- source/srt_qselect.sv
module srt_qselect (
    input  logic [3:0]        b_i,
    input  logic signed [5:0] p_i,
    output div_pkg::qdigit_t  q_o
);
    import div_pkg::*;

    // exclusive upper bounds of the -2, -1, 0 and +1 regions in the current row
    logic signed [5:0] lim_n2;
    logic signed [5:0] lim_n1;
    logic signed [5:0] lim_z;
    logic signed [5:0] lim_p1;

    // where two regions overlap the bound is taken from the lower digit
    always_comb begin
        case (b_i)
            4'b1001: begin
                lim_n2 = -6'sd7;
                lim_n1 = -6'sd2;
                lim_z  = 6'sd3;
                lim_p1 = 6'sd7;
            end
            4'b1010: begin
                lim_n2 = -6'sd8;
                lim_n1 = -6'sd2;
                lim_z  = 6'sd3;
                lim_p1 = 6'sd8;
            end
            4'b1011: begin
                lim_n2 = -6'sd8;
                lim_n1 = -6'sd2;
                lim_z  = 6'sd3;
                lim_p1 = 6'sd9;
            end
            4'b1100: begin
                lim_n2 = -6'sd9;
                lim_n1 = -6'sd3;
                lim_z  = 6'sd4;
                lim_p1 = 6'sd10;
            end
            4'b1101: begin
                lim_n2 = -6'sd10;
                lim_n1 = -6'sd3;
                lim_z  = 6'sd4;
                lim_p1 = 6'sd10;
            end
            4'b1110: begin
                lim_n2 = -6'sd10;
                lim_n1 = -6'sd3;
                lim_z  = 6'sd4;
                lim_p1 = 6'sd11;
            end
            4'b1111: begin
                lim_n2 = -6'sd11;
                lim_n1 = -6'sd3;
                lim_z  = 6'sd5;
                lim_p1 = 6'sd12;
            end
            default: begin  // 1000, and a zero divisor whose result is replaced later
                lim_n2 = -6'sd6;
                lim_n1 = -6'sd2;
                lim_z  = 6'sd2;
                lim_p1 = 6'sd6;
            end
        endcase
    end

    always_comb begin
        if (p_i < lim_n2) begin
            q_o = QD_N2;
        end else if (p_i < lim_n1) begin
            q_o = QD_N1;
        end else if (p_i < lim_z) begin
            q_o = QD_Z;
        end else if (p_i < lim_p1) begin
            q_o = QD_P1;
        end else begin
            q_o = QD_P2;
        end
    end

endmodule

//--- test/div_golden.txt
# op dividend divisor expected, all hex
# op: 0 DIV, 1 DIVU, 2 REM, 3 REMU
1 00000064 00000007 0000000e
3 00000064 00000007 00000002
1 00000005 0000000a 00000000
3 00000005 0000000a 00000005
1 ffffffff 00000001 ffffffff
3 ffffffff 00000001 00000000
1 ffffffff ffffffff 00000001
3 ffffffff 00000010 0000000f
1 12345678 00001000 00012345
3 12345678 00001000 00000678
1 80000000 00000003 2aaaaaaa
3 80000000 00000003 00000002
1 deadbeef 00010000 0000dead
3 deadbeef 00010000 0000beef
3 fffffffe ffffffff fffffffe
1 000f4240 00000007 00022e09
3 000f4240 00000007 00000001
0 00000007 00000002 00000003
2 00000007 00000002 00000001
0 fffffff9 00000002 fffffffd
2 fffffff9 00000002 ffffffff
0 00000007 fffffffe fffffffd
2 00000007 fffffffe 00000001
0 fffffff9 fffffffe 00000003
2 fffffff9 fffffffe ffffffff
0 ffffff9c 00000007 fffffff2
2 ffffff9c 00000007 fffffffe
0 80000000 00000002 c0000000
2 80000000 00000002 00000000
0 7fffffff 80000000 00000000
2 7fffffff 80000000 7fffffff
0 12345678 00000000 ffffffff
1 12345678 00000000 ffffffff
2 87654321 00000000 87654321
3 87654321 00000000 87654321
0 80000000 ffffffff 80000000
2 80000000 ffffffff 00000000
1 80000000 ffffffff 00000000
3 80000000 ffffffff 80000000

//--- test/tb_div_unit.sv
module tb_div_unit;
    import div_pkg::*;

    localparam int CLK_T   = 100;
    localparam int LAT_CNT = 6;  // leading entries go back to back with the output always ready

    logic            clk;
    logic            rst;
    logic            req_valid_i;
    logic            req_ready_o;
    div_req_t        req_i;
    logic            res_valid_o;
    logic            res_ready_i;
    logic [XLEN-1:0] res_o;

    div_req_t        req_tab[$];
    logic [XLEN-1:0] exp_tab[$];
    int              req_edge[$];  // rising edge on which each request was accepted
    logic [31:0]     lfsr_state;
    int              n_ent;
    int              n_req;
    int              n_res;
    bit              loaded;

    div_unit u_dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_o       (res_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_T / 2) clk = ~clk;
    end

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit taken
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic load_golden();
        int              fd;
        int              cnt;
        string           line;
        logic [1:0]      op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] e;
        div_req_t        r;
        fd = $fopen("test/div_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open test/div_golden.txt for reading");
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            // blank lines and lines starting with # carry no entry
            if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                cnt = $sscanf(line, "%h %h %h %h", op, a, b, e);
                if (cnt != 4) begin
                    abort_run($sformatf("golden file line cannot be parsed: %s", line));
                end
                r.op       = div_op_e'(op);
                r.dividend = a;
                r.divisor  = b;
                req_tab.push_back(r);
                exp_tab.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int gap;
        int rdy;
        int edge_no;
        bit req_fire;
        lfsr_state  = 32'h1edf_220a;
        rst         = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        res_ready_i = 1'b0;
        n_req       = 0;
        n_res       = 0;
        load_golden();
        n_ent  = req_tab.size();
        loaded = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_value("res_valid_o", XLEN'(res_valid_o), XLEN'(0));
        check_value("req_ready_o", XLEN'(req_ready_o), XLEN'(1));

        gap      = 0;
        req_fire = 1'b0;
        edge_no  = 0;
        while (n_res < n_ent) begin
            @(negedge clk);
            edge_no++;  // number of the coming rising edge
            if (req_fire) begin
                req_valid_i = 1'b0;
                n_req++;
                if (n_req >= LAT_CNT) begin
                    draw_bits(2, gap);
                end
            end
            if (!req_valid_i && n_req < n_ent) begin
                if (gap == 0) begin
                    req_valid_i = 1'b1;
                    req_i       = req_tab[n_req];
                end else begin
                    gap--;
                end
            end
            if (n_res < LAT_CNT) begin
                res_ready_i = 1'b1;
            end else begin
                draw_bits(1, rdy);
                res_ready_i = rdy[0];
            end

            // outputs only move on rising edges, so these are the handshakes of the next one
            if (res_valid_o && res_ready_i) begin
                if (n_res >= n_req) begin
                    abort_run("a result appeared while no request was outstanding");
                end
                check_value($sformatf("res_o[%0d]", n_res), res_o, exp_tab[n_res]);
                if (n_res < LAT_CNT) begin
                    check_value($sformatf("latency[%0d]", n_res),
                                XLEN'(edge_no - req_edge[n_res]), XLEN'(ITER_STEPS + 2));
                end
                n_res++;
            end
            req_fire = req_valid_i && req_ready_o;
            if (req_fire) begin
                req_edge.push_back(edge_no);
            end
        end

        // nothing may follow the last result
        res_ready_i = 1'b1;
        repeat (ITER_STEPS + 4) begin
            @(negedge clk);
            if (res_valid_o) begin
                abort_run("an extra result appeared after the last expected one");
            end
        end

        if (n_res == n_ent && n_req == n_ent) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("the number of accepted requests and results does not match the file");
        end
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(n_ent) * longint'(ITER_STEPS + 40) * longint'(CLK_T);
        #(limit);
        abort_run("watchdog expired before all results arrived");
    end

endmodule
